// ==== design/cache_lru_defs.svh ====
// cache lru sizing defines
`ifndef CACHE_LRU_DEFS_SVH
`define CACHE_LRU_DEFS_SVH

// ---------------------------------------------------------------------------
// cache geometry
// ---------------------------------------------------------------------------

// number of addressable cache blocks
`define CACHE_BLOCK_CAPACITY 64

// ways per group, 2 4 or 8
`define CACHE_SET_SIZE 4

// ---------------------------------------------------------------------------
// derived address widths
// ---------------------------------------------------------------------------
//
//		block address  [ way (BW_SET) | group (BW_GRP) ]
//
// the way field sits in the upper bits and the group field in the lower
// bits, so neighbouring blocks land in different groups

// block address width
`define BW_CACHE_CAPACITY $clog2(`CACHE_BLOCK_CAPACITY)

// way field width, also wide enough to hold an age
`define BW_SET $clog2(`CACHE_SET_SIZE)

// group field width, whatever is left of the block address
`define BW_GRP (`BW_CACHE_CAPACITY - `BW_SET)

// one line controller per group
`define N_GROUPS (2 ** `BW_GRP)

// 64 blocks 4 ways gives 6 address bits, 2 way bits,
// 4 group bits and 16 line controllers

`endif

// ==== design/cache_lru_pkg.sv ====
// cache lru shared types
`default_nettype none

`include "cache_lru_defs.svh"

package cache_lru_pkg;

	// ---------------------------------------------------------------------------
	// address types
	// ---------------------------------------------------------------------------

	typedef logic [`BW_CACHE_CAPACITY-1:0] block_addr_t;	// full [way | group] address
	typedef logic [`BW_SET-1:0] way_t;	// way index, doubles as an age value
	typedef logic [`BW_GRP-1:0] group_t;	// group index

	// ages run 0 (most recent) to N-1 (oldest), one per way,
	// so they always fit in a way_t

	// ---------------------------------------------------------------------------
	// line controller states
	// ---------------------------------------------------------------------------

	typedef enum logic [1:0] {
		idle,	// waiting for a pulse
		search,	// victim scan running
		fill	// victim promoted, done held high
	} lru_state_e;

endpackage

`default_nettype wire

// ==== design/lru_victim_search.sv ====
// lru victim search
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

// walks one way per cycle looking for the oldest age
//
//	edge k		start_i sampled, counter cleared
//	edge k+1..k+N	way 0..N-1 compared against N-1
//	after k+N	found_o high for one cycle, victim_o valid

module lru_victim_search #(
	parameter int N_LOCATIONS = `CACHE_SET_SIZE	// ways in the group
)(
	input wire clock_i,
	input wire arst_n_i,
	input wire start_i,	// one-cycle pulse, begins a scan
	input wire cache_lru_pkg::way_t ages_i [N_LOCATIONS],	// ages of the group
	output logic found_o,	// one-cycle pulse, victim_o is valid
	output cache_lru_pkg::way_t victim_o	// way holding the oldest age
);

	localparam cache_lru_pkg::way_t OLDEST = cache_lru_pkg::way_t'(N_LOCATIONS - 1);
	localparam cache_lru_pkg::way_t LAST_WAY = cache_lru_pkg::way_t'(N_LOCATIONS - 1);

	logic busy_q;	// scan in progress
	logic found_q;
	cache_lru_pkg::way_t way_cnt_q;	// way under test
	cache_lru_pkg::way_t victim_q;	// last way seen with the oldest age

	// ---------------------------------------------------------------------------
	// scan control
	// ---------------------------------------------------------------------------

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			found_q <= 1'b0;
			way_cnt_q <= '0;
		end else begin
			found_q <= 1'b0;	// pulse by default
			if (start_i) begin
				busy_q <= 1'b1;
				way_cnt_q <= '0;	// always scan from way 0
			end else if (busy_q) begin
				way_cnt_q <= way_cnt_q + 1'b1;
				if (way_cnt_q == LAST_WAY) begin	// last way checked this edge
					busy_q <= 1'b0;
					found_q <= 1'b1;
				end
			end
		end
	end

	// a single equality compare per cycle
	// exactly one way holds N-1, so the capture fires once per scan
	always_ff @(posedge clock_i) begin
		if (busy_q && (ages_i[way_cnt_q] == OLDEST)) begin
			victim_q <= way_cnt_q;
		end
	end

	assign found_o = found_q;
	assign victim_o = victim_q;	// stable until the next scan hits

endmodule

`default_nettype wire

// ==== design/lru_line_controller.sv ====
// lru line controller
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

// holds the true-lru ages of one group
//
//	idle	--miss-->	search	--found-->	fill
//	fill	--miss-->	search
//	fill	--any other pulse-->	idle
//
// promotion sets the chosen way to age 0 and ages every way that was
// more recent than it by one, so the ages stay a permutation of 0..N-1

module lru_line_controller #(
	parameter int N_LOCATIONS = `CACHE_SET_SIZE	// ways in the group
)(
	input wire clock_i,
	input wire arst_n_i,
	input wire enable_i,	// this group is addressed
	input wire hit_i,	// pulse, promote addr_i
	input wire miss_i,	// pulse, find a victim
	input wire cache_lru_pkg::way_t addr_i,	// way field of the address
	output logic done_o,	// victim ready, held until the next pulse
	output cache_lru_pkg::way_t addr_o	// victim way
);

	cache_lru_pkg::lru_state_e state_q;
	cache_lru_pkg::way_t ages_q [N_LOCATIONS];	// age per way, 0 is most recent
	cache_lru_pkg::way_t victim_q;	// victim latched for addr_o
	logic done_q;

	logic start;	// kicks the victim search
	logic found;
	cache_lru_pkg::way_t victim;
	logic promote_en;
	cache_lru_pkg::way_t promote_way;
	cache_lru_pkg::way_t promote_age;	// old age of the promoted way

	// ---------------------------------------------------------------------------
	// victim search
	// ---------------------------------------------------------------------------

	// a miss is taken unless a scan is already running
	assign start = enable_i && miss_i && (state_q != cache_lru_pkg::search);

	lru_victim_search #(
		.N_LOCATIONS (N_LOCATIONS)
	) lru_victim_search_i (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.start_i (start),
		.ages_i (ages_q),	// ages stay frozen while scanning
		.found_o (found),
		.victim_o (victim)
	);

	// ---------------------------------------------------------------------------
	// promotion select
	// ---------------------------------------------------------------------------

	always_comb begin
		promote_en = 1'b0;
		promote_way = addr_i;	// hit path by default
		case (state_q)
			cache_lru_pkg::search: begin
				promote_en = found;	// victim is about to be filled
				promote_way = victim;
			end
			default: promote_en = enable_i && hit_i;	// hits ignored mid-scan
		endcase
	end

	assign promote_age = ages_q[promote_way];

	// reset age of way w is N-1-w, way 0 starts oldest
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int w = 0; w < N_LOCATIONS; w++) begin
				ages_q[w] <= cache_lru_pkg::way_t'(N_LOCATIONS - 1 - w);
			end
		end else if (promote_en) begin
			for (int w = 0; w < N_LOCATIONS; w++) begin
				if (cache_lru_pkg::way_t'(w) == promote_way) begin
					ages_q[w] <= '0;	// now most recent
				end else if (ages_q[w] < promote_age) begin
					ages_q[w] <= ages_q[w] + 1'b1;	// one step older
				end
			end
		end
	end

	// ---------------------------------------------------------------------------
	// state machine and done
	// ---------------------------------------------------------------------------

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= cache_lru_pkg::idle;
			done_q <= 1'b0;
		end else begin
			case (state_q)
				cache_lru_pkg::idle: begin
					if (start) state_q <= cache_lru_pkg::search;
				end
				cache_lru_pkg::search: begin
					if (found) begin
						state_q <= cache_lru_pkg::fill;
						done_q <= 1'b1;	// one cycle after found
					end
				end
				cache_lru_pkg::fill: begin
					// any pulse ends the fill, even one aimed at another group,
					// so no stale done survives a change of group
					if (start) begin
						state_q <= cache_lru_pkg::search;
						done_q <= 1'b0;
					end else if (hit_i || miss_i) begin
						state_q <= cache_lru_pkg::idle;
						done_q <= 1'b0;
					end
				end
				default: begin
					state_q <= cache_lru_pkg::idle;
					done_q <= 1'b0;
				end
			endcase
		end
	end

	// victim held on addr_o for as long as done is high
	always_ff @(posedge clock_i) begin
		if ((state_q == cache_lru_pkg::search) && found) victim_q <= victim;
	end

	assign done_o = done_q;
	assign addr_o = victim_q;

endmodule

`default_nettype wire

// ==== design/set_cache_lru_policy_controller.sv ====
// lru policy controller
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

// block address layout
// ---------------------------------------------------------------------------
//
//		[ way | group ]
//
// routing
// ---------------------------------------------------------------------------
//
// the group field picks one line controller; hit, miss and the way field
// go to every controller and only the enabled one acts on them
//
// done and the victim way come back through a plain mux on the group,
// no registers here, so the outputs follow the line controllers in the
// same cycle

module set_cache_lru_policy_controller (
	input wire clock_i,
	input wire arst_n_i,
	input wire hit_i,	// pulse, makes addr_i most recent
	input wire miss_i,	// pulse, asks for a replacement address
	input wire cache_lru_pkg::block_addr_t addr_i,
	output logic done_o,	// replacement address valid
	output cache_lru_pkg::block_addr_t addr_o	// replacement address
);

	// ---------------------------------------------------------------------------
	// address split
	// ---------------------------------------------------------------------------

	cache_lru_pkg::way_t addr_way;
	cache_lru_pkg::group_t addr_group;

	assign addr_way = addr_i[`BW_CACHE_CAPACITY-1:`BW_GRP];	// upper bits
	assign addr_group = addr_i[`BW_GRP-1:0];	// lower bits

	// per-group routing
	logic [`N_GROUPS-1:0] enable_bus;	// one-hot group enable
	logic [`N_GROUPS-1:0] done_bus;	// done level of each group
	cache_lru_pkg::way_t victim_bus [`N_GROUPS];	// victim way of each group

	// ---------------------------------------------------------------------------
	// line controllers, one per group
	// ---------------------------------------------------------------------------

	for (genvar g = 0; g < `N_GROUPS; g++) begin : g_line

		// one-hot decode, one comparator per group
		assign enable_bus[g] = (addr_group == cache_lru_pkg::group_t'(g));

		lru_line_controller #(
			.N_LOCATIONS (`CACHE_SET_SIZE)
		) lru_line_controller_i (
			.clock_i (clock_i),
			.arst_n_i (arst_n_i),
			.enable_i (enable_bus[g]),
			.hit_i (hit_i),	// broadcast
			.miss_i (miss_i),	// broadcast
			.addr_i (addr_way),	// broadcast
			.done_o (done_bus[g]),
			.addr_o (victim_bus[g])
		);
	end

	// ---------------------------------------------------------------------------
	// output select
	// ---------------------------------------------------------------------------

	// addr_i is held steady while a search runs, so the mux does not move
	// under the addressed group
	cache_lru_pkg::way_t sel_victim;

	assign sel_victim = victim_bus[addr_group];
	assign done_o = done_bus[addr_group];
	assign addr_o = {sel_victim, addr_group};	// victim way back over its group

endmodule

`default_nettype wire

// ==== design/cache_lru_replacement.sv ====
// cache lru replacement top
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

// replacement policy for a set-associative cache
// ---------------------------------------------------------------------------
//
// hit and miss arrive from the cache controller as one-cycle pulses with
// addr_i valid on the same cycle
//
//	hit	ages updated on the next edge
//	miss	done_o high N+1 edges later, addr_o holds the victim
//
// done_o drops on the edge that samples the next pulse. no pulse and no
// change of addr_i is allowed while a search is running

module cache_lru_replacement (
	input wire clock_i,
	input wire arst_n_i,
	input wire hit_i,	// hit pulse
	input wire miss_i,	// miss pulse
	input wire cache_lru_pkg::block_addr_t addr_i,	// [way | group]
	output logic done_o,	// replacement ready
	output cache_lru_pkg::block_addr_t addr_o	// block to replace
);

	// ---------------------------------------------------------------------------
	// policy controller
	// ---------------------------------------------------------------------------

	logic policy_done;
	cache_lru_pkg::block_addr_t policy_addr;

	set_cache_lru_policy_controller set_cache_lru_policy_controller_i (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.hit_i (hit_i),
		.miss_i (miss_i),
		.addr_i (addr_i),
		.done_o (policy_done),
		.addr_o (policy_addr)
	);

	assign done_o = policy_done;
	assign addr_o = policy_addr;	// [victim way | group]

endmodule

`default_nettype wire

// ==== dv/cache_lru_replacement_sva.sv ====
// cache lru bound assertions
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

module cache_lru_replacement_sva (
	input wire clock_i,
	input wire arst_n_i,
	input wire hit_i,
	input wire miss_i,
	input wire cache_lru_pkg::block_addr_t addr_i,
	input wire done_o,	// observed, not driven
	input wire cache_lru_pkg::block_addr_t addr_o
);

	localparam int N = `CACHE_SET_SIZE;

	int unsigned fail_count = 0;	// read by the testbench monitor
	logic busy_q;	// miss taken, done not yet up
	logic due_q;	// done must be high on this sample
	int wait_q;	// cycles since the miss edge

	// ---------------------------------------------------------------------------
	// search window tracker
	// ---------------------------------------------------------------------------

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			due_q <= 1'b0;
			wait_q <= 0;
		end else begin
			due_q <= 1'b0;
			if (miss_i && !busy_q) begin
				busy_q <= 1'b1;
				wait_q <= 1;
			end else if (busy_q) begin
				wait_q <= wait_q + 1;
				if (wait_q == N + 1) begin	// done rises on this edge
					busy_q <= 1'b0;
					due_q <= 1'b1;
				end
			end
		end
	end

	// ---------------------------------------------------------------------------
	// properties
	// ---------------------------------------------------------------------------

	a_reset: assert property (@(posedge clock_i) !arst_n_i |-> !done_o)
		else begin fail_count++; $error("done_o high while in reset"); end

	// no pulse and a steady address while the scan runs
	a_quiet: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		busy_q |-> (!hit_i && !miss_i && $stable(addr_i)))
		else begin fail_count++; $error("input moved during a victim search"); end

	a_early: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		busy_q |-> !done_o)
		else begin fail_count++; $error("done_o rose before N+1 cycles"); end

	a_rise: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		due_q |-> done_o)
		else begin fail_count++; $error("done_o not high N+1 cycles after miss"); end

	// done and victim hold until a pulse or a new address
	a_hold: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		(done_o && !hit_i && !miss_i) |=> (!$stable(addr_i) || (done_o && $stable(addr_o))))
		else begin fail_count++; $error("done_o or addr_o moved without a pulse"); end

	a_fall: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		(done_o && (hit_i || miss_i)) |=> !done_o)
		else begin fail_count++; $error("done_o stayed high after a pulse"); end

endmodule

bind cache_lru_replacement cache_lru_replacement_sva cache_lru_replacement_sva_i (
	.clock_i (clock_i),
	.arst_n_i (arst_n_i),
	.hit_i (hit_i),
	.miss_i (miss_i),
	.addr_i (addr_i),
	.done_o (done_o),
	.addr_o (addr_o)
);

`default_nettype wire

// ==== dv/cache_lru_replacement_tb.sv ====
// cache lru replacement testbench
`timescale 1ns/100ps
`default_nettype none

`include "cache_lru_defs.svh"

module cache_lru_replacement_tb;

	localparam int N = `CACHE_SET_SIZE;
	localparam int NG = `N_GROUPS;
	localparam int N_OPS = 3 + N + 9 + 7 + 2 + 200;	// ops over all tests
	localparam int WATCHDOG_CYCLES = N_OPS * (N + 4) + 100;

	logic clock;
	logic arst_n;
	logic hit;
	logic miss;
	cache_lru_pkg::block_addr_t addr;
	logic done;
	cache_lru_pkg::block_addr_t repl_addr;

	cache_lru_pkg::block_addr_t exp_victim;	// model victim of the current miss
	int exp_done_cycle;	// model cycle of done rising
	int cycle_count = 0;
	int seed = 32'h2fef;
	int recency [NG][N];	// per group, slot 0 most recent

	cache_lru_replacement cache_lru_replacement_i (
		.clock_i (clock),
		.arst_n_i (arst_n),
		.hit_i (hit),
		.miss_i (miss),
		.addr_i (addr),
		.done_o (done),
		.addr_o (repl_addr)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) cycle_count <= cycle_count + 1;

	// ---------------------------------------------------------------------------
	// failure reporting and recency model
	// ---------------------------------------------------------------------------

	task automatic report_failure(input string reason);
		$display("Errors found");
		$fatal(1, "%s", reason);
	endtask

	task automatic value_error(input string name, input int expected, input int actual);
		$display("error: %s expected %0h actual %0h", name, expected, actual);
		report_failure("value mismatch");
	endtask

	// move a way to the front of its group list
	task automatic promote(input int g, input int w);
		int pos;
		pos = 0;
		for (int p = 0; p < N; p++) begin
			if (recency[g][p] == w) pos = p;
		end
		for (int p = pos; p > 0; p--) recency[g][p] = recency[g][p-1];
		recency[g][0] = w;
	endtask

	task automatic run_hit(input int g, input int w);
		@(posedge clock);
		#10;
		hit = 1'b1;
		addr = {cache_lru_pkg::way_t'(w), cache_lru_pkg::group_t'(g)};
		@(posedge clock);
		#10;
		hit = 1'b0;
		promote(g, w);
	endtask

	// miss on a group, wait for done, compare latency and victim
	task automatic run_miss(input string name, input int g, output int victim_way);
		int v;
		v = recency[g][N-1];	// oldest entry of the list
		exp_victim = {cache_lru_pkg::way_t'(v), cache_lru_pkg::group_t'(g)};
		@(posedge clock);
		#10;
		miss = 1'b1;
		addr = {cache_lru_pkg::way_t'(0), cache_lru_pkg::group_t'(g)};
		@(posedge clock);	// miss sampled here
		#10;
		miss = 1'b0;
		exp_done_cycle = cycle_count + N + 1;
		@(negedge clock);
		while (!done) @(negedge clock);
		assert (cycle_count == exp_done_cycle)
			else value_error({name, " latency"}, exp_done_cycle, cycle_count);
		assert (repl_addr == exp_victim)
			else value_error(name, int'(exp_victim), int'(repl_addr));
		promote(g, v);	// filled line is now most recent
		victim_way = int'(repl_addr[`BW_CACHE_CAPACITY-1:`BW_GRP]);	// way the DUT returned
	endtask

	// bound checker failures end the run here
	always @(negedge clock) begin
		if (cache_lru_replacement_i.cache_lru_replacement_sva_i.fail_count != 0)
			report_failure("a bound assertion failed");
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		report_failure("watchdog expired before the tests finished");
	end

	// ---------------------------------------------------------------------------
	// test sequence
	// ---------------------------------------------------------------------------

	initial begin
		int v;
		int mv;
		int r;
		int g;
		arst_n = 1'b0;
		hit = 1'b0;
		miss = 1'b0;
		addr = '0;
		exp_victim = '0;
		exp_done_cycle = 0;
		for (int i = 0; i < NG; i++) begin
			for (int p = 0; p < N; p++) recency[i][p] = N - 1 - p;
		end
		repeat (5) @(posedge clock);
		#10;
		arst_n = 1'b1;
		@(negedge clock);
		assert (!done) else value_error("reset_state done", 0, int'(done));
		run_miss("reset_state", 0, v);	// fresh group gives way 0
		assert (v == 0) else value_error("reset_state", 0, v);
		run_miss("reset_state", 5 % NG, v);
		run_miss("reset_state", NG - 1, v);
		for (int i = 0; i < N; i++) begin	// fills rotate through the ways
			run_miss("miss_rotation", 1, v);
			assert (v == i) else value_error("miss_rotation", i, v);
		end
		repeat (8) run_hit(6 % NG, $unsigned($random(seed)) % N);
		run_miss("hit_promotion", 6 % NG, v);
		mv = recency[7 % NG][N-1];	// other group must not move
		for (int i = 0; i < 4; i++) run_hit(8 % NG, i % N);
		run_miss("group_independence", 8 % NG, v);
		run_miss("group_independence", 8 % NG, v);
		run_miss("group_independence", 7 % NG, v);
		assert (v == mv) else value_error("group_independence", mv, v);
		run_miss("done_timing", 9 % NG, v);
		mv = int'(repl_addr);
		repeat (6) begin	// held with no pulse
			@(negedge clock);
			assert (done) else value_error("done_timing level", 1, int'(done));
			assert (int'(repl_addr) == mv)
				else value_error("done_timing addr", mv, int'(repl_addr));
		end
		run_hit(9 % NG, 1);
		@(negedge clock);
		assert (!done) else value_error("done_timing fall", 0, int'(done));
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			g = $unsigned($random(seed)) % NG;
			if (r[0]) run_hit(g, $unsigned($random(seed)) % N);
			else run_miss("random_mix", g, v);
		end
		repeat (2) @(negedge clock);
		if (cache_lru_replacement_i.cache_lru_replacement_sva_i.fail_count != 0) begin
			report_failure("a bound assertion failed");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== cache_lru_replacement.f ====
+incdir+design
design/cache_lru_pkg.sv
design/lru_victim_search.sv
design/lru_line_controller.sv
design/set_cache_lru_policy_controller.sv
design/cache_lru_replacement.sv
dv/cache_lru_replacement_sva.sv
dv/cache_lru_replacement_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module cache_lru_replacement_tb \
	-f cache_lru_replacement.f \
	-o sim_cache_lru

if ! sim_out=$(./obj_dir/sim_cache_lru 2>&1); then
	echo "$sim_out"
	exit 1
fi
echo "$sim_out"

echo "$sim_out" | grep -q "No errors"
